// ==== include/tinker_consts.svh ====
`ifndef TINKER_CONSTS_SVH
`define TINKER_CONSTS_SVH

// datapath widths
`define TK_XLEN 64   // register and data word
`define TK_ALEN 32   // pc and byte address
`define TK_RIDX 5    // register index
`define TK_LIT  12   // instruction literal

// reset values
`define TK_PC_RESET 32'h0000_2000
`define TK_SP_RESET 64'h0000_0000_0008_0000   // initial r31

// mov r0,r0, opcode 0x11 in bits 31:27
`define TK_NOP     32'h8800_0000
`define TK_PC_STEP 32'd4                       // bytes per instruction

// logic and shifts
`define TK_OP_AND    5'h00
`define TK_OP_OR     5'h01
`define TK_OP_XOR    5'h02
`define TK_OP_NOT    5'h03
`define TK_OP_SHFTR  5'h04
`define TK_OP_SHFTRI 5'h05
`define TK_OP_SHFTL  5'h06
`define TK_OP_SHFTLI 5'h07
// control flow
`define TK_OP_BR     5'h08   // pc = rd
`define TK_OP_BRR    5'h09   // pc += rd
`define TK_OP_BRRL   5'h0a   // pc += sext(L)
`define TK_OP_BRNZ   5'h0b
`define TK_OP_BRGT   5'h0e
`define TK_OP_HALT   5'h0f
// moves and memory
`define TK_OP_LOAD   5'h10   // mov rd,(rs)(L)
`define TK_OP_MOV    5'h11   // mov rd,rs
`define TK_OP_MOVL   5'h12   // mov rd,L
`define TK_OP_STORE  5'h13   // mov (rd)(L),rs
// integer arithmetic
`define TK_OP_ADD    5'h18
`define TK_OP_ADDI   5'h19
`define TK_OP_SUB    5'h1a
`define TK_OP_SUBI   5'h1b
`define TK_OP_MUL    5'h1c

`endif

// ==== src/tinker_pkg.sv ====
`include "tinker_consts.svh"

package tinker_pkg;

    // instruction word, msb first
    typedef struct packed {
        logic [4:0]          opcode;
        logic [`TK_RIDX-1:0] rd;
        logic [`TK_RIDX-1:0] rs;
        logic [`TK_RIDX-1:0] rt;
        logic [`TK_LIT-1:0]  lit;
    } instr_t;

    typedef struct packed {
        logic reg_write;   // rd written in WB
        logic mem_read;    // load in MEM
        logic mem_write;   // store in MEM
        logic mem_to_reg;  // WB takes load data
        logic is_branch;
        logic halt;
    } ctrl_t;

    // EX operand source
    typedef enum logic [1:0] {
        from_rf    = 2'd0,
        from_exmem = 2'd1,
        from_memwb = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [4:0]          opcode;
        logic [`TK_RIDX-1:0] rd;
        logic [`TK_RIDX-1:0] rs;
        logic [`TK_RIDX-1:0] rt;
        logic [`TK_LIT-1:0]  lit;
        logic [`TK_XLEN-1:0] rd_val;
        logic [`TK_XLEN-1:0] rs_val;
        logic [`TK_XLEN-1:0] rt_val;
    } idex_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [`TK_XLEN-1:0] alu_result;   // also the memory address
        logic [`TK_XLEN-1:0] store_data;
        logic [`TK_RIDX-1:0] rd_dest;
    } exmem_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [`TK_XLEN-1:0] mem_data;
        logic [`TK_XLEN-1:0] alu_result;
        logic [`TK_RIDX-1:0] rd_dest;
    } memwb_t;

    // writeback, shared by regfile, forwarding and retire
    typedef struct packed {
        logic                we;
        logic [`TK_RIDX-1:0] dest;
        logic [`TK_XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic                we;
        logic [`TK_ALEN-1:0] addr;
        logic [`TK_XLEN-1:0] data;
    } store_t;

endpackage

// ==== src/tinker_decode.sv ====
`include "tinker_consts.svh"

module tinker_decode (
    input  tinker_pkg::instr_t instr,
    output tinker_pkg::ctrl_t  ctrl
);

    always_comb begin
        ctrl = '0;   // unknown opcode behaves as a nop
        case (instr.opcode)
            // result lands in rd
            `TK_OP_ADD, `TK_OP_ADDI, `TK_OP_SUB, `TK_OP_SUBI, `TK_OP_MUL,
            `TK_OP_AND, `TK_OP_OR, `TK_OP_XOR, `TK_OP_NOT,
            `TK_OP_SHFTR, `TK_OP_SHFTRI, `TK_OP_SHFTL, `TK_OP_SHFTLI,
            `TK_OP_MOV, `TK_OP_MOVL: begin
                ctrl.reg_write = 1'b1;
            end
            `TK_OP_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;   // hazard unit watches this
                ctrl.mem_to_reg = 1'b1;
            end
            `TK_OP_STORE: begin
                ctrl.mem_write = 1'b1;    // address rd+L, data rs
            end
            // resolved in ID, nothing later
            `TK_OP_BR, `TK_OP_BRR, `TK_OP_BRRL, `TK_OP_BRNZ, `TK_OP_BRGT: begin
                ctrl.is_branch = 1'b1;
            end
            `TK_OP_HALT: begin
                ctrl.halt = 1'b1;         // rides to WB then raises hlt
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== src/tinker_regfile.sv ====
`include "tinker_consts.svh"

module tinker_regfile (
    input  logic                clk,
    input  logic                reset,
    input  tinker_pkg::wb_t     wb,
    input  logic [`TK_RIDX-1:0] rd_idx,
    input  logic [`TK_RIDX-1:0] rs_idx,
    input  logic [`TK_RIDX-1:0] rt_idx,
    output logic [`TK_XLEN-1:0] rd_val,
    output logic [`TK_XLEN-1:0] rs_val,
    output logic [`TK_XLEN-1:0] rt_val
);

    logic [`TK_XLEN-1:0] regs [2**`TK_RIDX];

    // write-first: a WB write in this cycle wins over the stored value
    function automatic logic [`TK_XLEN-1:0] read_port(
        input logic [`TK_RIDX-1:0] idx,
        input logic [`TK_XLEN-1:0] stored,
        input tinker_pkg::wb_t     w
    );
        return (w.we && w.dest == idx) ? w.data : stored;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**`TK_RIDX - 1; i++) begin
                regs[i] <= '0;
            end
            regs[2**`TK_RIDX - 1] <= `TK_SP_RESET;   // r31 is the stack pointer
        end else if (wb.we) begin
            regs[wb.dest] <= wb.data;
        end
    end

    assign rd_val = read_port(rd_idx, regs[rd_idx], wb);
    assign rs_val = read_port(rs_idx, regs[rs_idx], wb);
    assign rt_val = read_port(rt_idx, regs[rt_idx], wb);

    // a write with an unknown index would corrupt the whole file
    a_wb_dest_known: assert property (@(posedge clk) disable iff (reset)
        wb.we |-> !$isunknown(wb.dest));

endmodule

// ==== src/tinker_branch.sv ====
`include "tinker_consts.svh"

module tinker_branch (
    input  logic [4:0]          opcode,
    input  logic [`TK_LIT-1:0]  lit,
    input  logic [`TK_ALEN-1:0] pc,       // pc of the branch itself
    input  logic [`TK_XLEN-1:0] rd_val,
    input  logic [`TK_XLEN-1:0] rs_val,
    input  logic [`TK_XLEN-1:0] rt_val,
    output logic                take_branch,
    output logic [`TK_ALEN-1:0] branch_target
);

    logic [`TK_ALEN-1:0] lit_ext;

    // byte offset, no scaling
    assign lit_ext = {{(`TK_ALEN-`TK_LIT){lit[`TK_LIT-1]}}, lit};

    always_comb begin
        take_branch   = 1'b0;
        branch_target = rd_val[`TK_ALEN-1:0];   // absolute target, the common case
        case (opcode)
            `TK_OP_BR:   take_branch = 1'b1;
            `TK_OP_BRR: begin
                take_branch   = 1'b1;
                branch_target = pc + rd_val[`TK_ALEN-1:0];
            end
            `TK_OP_BRRL: begin
                take_branch   = 1'b1;
                branch_target = pc + lit_ext;
            end
            `TK_OP_BRNZ: take_branch = (rs_val != '0);
            `TK_OP_BRGT: take_branch = ($signed(rs_val) > $signed(rt_val));
            default:     take_branch = 1'b0;
        endcase
    end

    // operands come straight from the regfile, no forwarding here;
    // producers must sit three or more slots ahead

endmodule

// ==== src/tinker_hazard.sv ====
module tinker_hazard (
    input  logic                  clk,
    input  logic                  reset,
    input  tinker_pkg::idex_t     idex,
    input  tinker_pkg::instr_t    id_instr,
    input  tinker_pkg::ctrl_t     exmem_ctrl,
    input  logic [4:0]            exmem_dest,
    input  tinker_pkg::ctrl_t     memwb_ctrl,
    input  logic [4:0]            memwb_dest,
    output logic                  stall,
    output tinker_pkg::fwd_sel_t  sel_rd,
    output tinker_pkg::fwd_sel_t  sel_rs,
    output tinker_pkg::fwd_sel_t  sel_rt
);

    // newest producer first
    function automatic tinker_pkg::fwd_sel_t pick(
        input logic [4:0]        idx,
        input tinker_pkg::ctrl_t ex_ctrl,
        input logic [4:0]        ex_dest,
        input tinker_pkg::ctrl_t wb_ctrl,
        input logic [4:0]        wb_dest
    );
        if (ex_ctrl.reg_write && ex_dest == idx) return tinker_pkg::from_exmem;
        if (wb_ctrl.reg_write && wb_dest == idx) return tinker_pkg::from_memwb;
        return tinker_pkg::from_rf;
    endfunction

    // load data only exists after MEM, so one bubble for any field match
    assign stall = idex.ctrl.mem_read &&
                   (idex.rd == id_instr.rd || idex.rd == id_instr.rs ||
                    idex.rd == id_instr.rt);

    always_comb begin
        sel_rd = pick(idex.rd, exmem_ctrl, exmem_dest, memwb_ctrl, memwb_dest);
        sel_rs = pick(idex.rs, exmem_ctrl, exmem_dest, memwb_ctrl, memwb_dest);
        sel_rt = pick(idex.rt, exmem_ctrl, exmem_dest, memwb_ctrl, memwb_dest);
    end

    // the bubble pushed into ID/EX must clear the load next cycle
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
        stall |=> !stall);

endmodule

// ==== src/tinker_alu.sv ====
`include "tinker_consts.svh"

module tinker_alu (
    input  logic [4:0]          opcode,
    input  logic [`TK_LIT-1:0]  lit,
    input  logic [`TK_XLEN-1:0] rd_val,   // forwarded
    input  logic [`TK_XLEN-1:0] rs_val,   // forwarded
    input  logic [`TK_XLEN-1:0] rt_val,   // forwarded
    output logic [`TK_XLEN-1:0] result
);

    logic [`TK_XLEN-1:0] lit_zext;
    logic [`TK_XLEN-1:0] lit_sext;

    assign lit_zext = {{(`TK_XLEN-`TK_LIT){1'b0}}, lit};   // immediates
    assign lit_sext = {{(`TK_XLEN-`TK_LIT){lit[`TK_LIT-1]}}, lit};   // mem offsets

    always_comb begin
        case (opcode)
            `TK_OP_ADD:    result = rs_val + rt_val;
            `TK_OP_ADDI:   result = rd_val + lit_zext;   // rd is source and dest
            `TK_OP_SUB:    result = rs_val - rt_val;
            `TK_OP_SUBI:   result = rd_val - lit_zext;
            `TK_OP_MUL:    result = rs_val * rt_val;     // low 64 bits kept
            `TK_OP_AND:    result = rs_val & rt_val;
            `TK_OP_OR:     result = rs_val | rt_val;
            `TK_OP_XOR:    result = rs_val ^ rt_val;
            `TK_OP_NOT:    result = ~rs_val;             // rt unused
            // logical shifts, amount taken whole
            `TK_OP_SHFTR:  result = rs_val >> rt_val;
            `TK_OP_SHFTRI: result = rd_val >> lit;
            `TK_OP_SHFTL:  result = rs_val << rt_val;
            `TK_OP_SHFTLI: result = rd_val << lit;
            `TK_OP_MOV:    result = rs_val;
            `TK_OP_MOVL: begin
                result = {rd_val[`TK_XLEN-1:`TK_LIT], lit};   // upper bits of rd survive
            end
            // effective addresses
            `TK_OP_LOAD:   result = rs_val + lit_sext;
            `TK_OP_STORE:  result = rd_val + lit_sext;
            default:       result = '0;
        endcase
    end

endmodule

// ==== src/tinker_core.sv ====
`include "tinker_consts.svh"

module tinker_core (
    input  logic                clk,
    input  logic                reset,
    output logic [`TK_ALEN-1:0] imem_addr,
    input  logic [31:0]         imem_data,        // same-cycle fetch
    output logic [`TK_ALEN-1:0] dmem_load_addr,
    input  logic [`TK_XLEN-1:0] dmem_load_data,   // same-cycle load
    output tinker_pkg::store_t  dmem_store,
    output tinker_pkg::wb_t     retire,
    output logic                hlt
);

    logic [`TK_ALEN-1:0]  pc;
    logic [`TK_ALEN-1:0]  pc_next;
    logic [`TK_ALEN-1:0]  ifid_pc;
    tinker_pkg::instr_t   ifid_instr;
    tinker_pkg::ctrl_t    id_ctrl;
    logic [`TK_XLEN-1:0]  id_rd_val, id_rs_val, id_rt_val;
    logic                 take_branch;
    logic [`TK_ALEN-1:0]  branch_target;
    logic                 stall;
    tinker_pkg::fwd_sel_t sel_rd, sel_rs, sel_rt;
    tinker_pkg::idex_t    idex, idex_d;
    tinker_pkg::exmem_t   exmem, exmem_d;
    tinker_pkg::memwb_t   memwb, memwb_d;
    tinker_pkg::wb_t      wb;
    logic [`TK_XLEN-1:0]  ex_rd_val, ex_rs_val, ex_rt_val;
    logic [`TK_XLEN-1:0]  alu_result;

    function automatic logic [`TK_XLEN-1:0] fwd_mux(
        input tinker_pkg::fwd_sel_t sel,
        input logic [`TK_XLEN-1:0]  rf_val,
        input logic [`TK_XLEN-1:0]  ex_val,
        input logic [`TK_XLEN-1:0]  wb_val
    );
        case (sel)
            tinker_pkg::from_exmem: return ex_val;
            tinker_pkg::from_memwb: return wb_val;
            default:                return rf_val;
        endcase
    endfunction

    // IF
    assign imem_addr = pc;
    assign pc_next   = take_branch ? branch_target : pc + `TK_PC_STEP;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `TK_PC_RESET;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ifid_pc    <= '0;
            ifid_instr <= tinker_pkg::instr_t'(`TK_NOP);
        end else if (!stall) begin   // hold on load-use
            ifid_pc    <= pc;
            // squash the fall-through slot behind a taken branch
            ifid_instr <= tinker_pkg::instr_t'(take_branch ? `TK_NOP : imem_data);
        end
    end

    // ID
    tinker_decode i_decode (
        .instr (ifid_instr),
        .ctrl  (id_ctrl)
    );

    tinker_regfile i_regfile (
        .clk    (clk),
        .reset  (reset),
        .wb     (wb),
        .rd_idx (ifid_instr.rd),
        .rs_idx (ifid_instr.rs),
        .rt_idx (ifid_instr.rt),
        .rd_val (id_rd_val),
        .rs_val (id_rs_val),
        .rt_val (id_rt_val)
    );

    tinker_branch i_branch (
        .opcode        (ifid_instr.opcode),
        .lit           (ifid_instr.lit),
        .pc            (ifid_pc),
        .rd_val        (id_rd_val),
        .rs_val        (id_rs_val),
        .rt_val        (id_rt_val),
        .take_branch   (take_branch),
        .branch_target (branch_target)
    );

    tinker_hazard i_hazard (
        .clk        (clk),
        .reset      (reset),
        .idex       (idex),
        .id_instr   (ifid_instr),
        .exmem_ctrl (exmem.ctrl),
        .exmem_dest (exmem.rd_dest),
        .memwb_ctrl (memwb.ctrl),
        .memwb_dest (memwb.rd_dest),
        .stall      (stall),
        .sel_rd     (sel_rd),
        .sel_rs     (sel_rs),
        .sel_rt     (sel_rt)
    );

    always_comb begin
        idex_d.ctrl   = id_ctrl;
        idex_d.opcode = ifid_instr.opcode;
        idex_d.rd     = ifid_instr.rd;
        idex_d.rs     = ifid_instr.rs;
        idex_d.rt     = ifid_instr.rt;
        idex_d.lit    = ifid_instr.lit;
        idex_d.rd_val = id_rd_val;
        idex_d.rs_val = id_rs_val;
        idex_d.rt_val = id_rt_val;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex <= '0;
        end else if (stall) begin
            idex <= '0;   // bubble, all control low
        end else begin
            idex <= idex_d;
        end
    end

    // EX, rd is a real source for immediates, mov L and store base
    always_comb begin
        ex_rd_val = fwd_mux(sel_rd, idex.rd_val, exmem.alu_result, wb.data);
        ex_rs_val = fwd_mux(sel_rs, idex.rs_val, exmem.alu_result, wb.data);
        ex_rt_val = fwd_mux(sel_rt, idex.rt_val, exmem.alu_result, wb.data);
    end

    tinker_alu i_alu (
        .opcode (idex.opcode),
        .lit    (idex.lit),
        .rd_val (ex_rd_val),
        .rs_val (ex_rs_val),
        .rt_val (ex_rt_val),
        .result (alu_result)
    );

    always_comb begin
        exmem_d.ctrl       = idex.ctrl;
        exmem_d.alu_result = alu_result;
        exmem_d.store_data = ex_rs_val;   // mov (rd)(L),rs stores rs
        exmem_d.rd_dest    = idex.rd;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem <= '0;
        end else begin
            exmem <= exmem_d;
        end
    end

    // MEM
    assign dmem_load_addr  = exmem.alu_result[`TK_ALEN-1:0];
    assign dmem_store.we   = exmem.ctrl.mem_write;
    assign dmem_store.addr = exmem.alu_result[`TK_ALEN-1:0];
    assign dmem_store.data = exmem.store_data;

    always_comb begin
        memwb_d.ctrl       = exmem.ctrl;
        memwb_d.mem_data   = dmem_load_data;   // only meaningful for loads
        memwb_d.alu_result = exmem.alu_result;
        memwb_d.rd_dest    = exmem.rd_dest;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memwb <= '0;
        end else begin
            memwb <= memwb_d;
        end
    end

    // WB, one channel for regfile, forwarding and retire
    assign wb.we   = memwb.ctrl.reg_write;
    assign wb.dest = memwb.rd_dest;
    assign wb.data = memwb.ctrl.mem_to_reg ? memwb.mem_data : memwb.alu_result;
    assign retire  = wb;
    assign hlt     = memwb.ctrl.halt;   // level while halt sits in MEM/WB

    // decode never pairs a store with a register write
    a_store_no_wb: assert property (@(posedge clk) disable iff (reset)
        !(exmem.ctrl.mem_write && exmem.ctrl.reg_write));

endmodule

// ==== tb/tinker_tb.sv ====
`include "tinker_consts.svh"

module tinker_tb;

    logic                clk = 1'b0;
    logic                reset;
    logic [`TK_ALEN-1:0] imem_addr;
    logic [31:0]         imem_data;
    logic [`TK_ALEN-1:0] dmem_load_addr;
    logic [`TK_XLEN-1:0] dmem_load_data;
    tinker_pkg::store_t  dmem_store;
    tinker_pkg::wb_t     retire;
    logic                hlt;

    logic [7:0]         tb_mem  [0:65535];   // memory the DUT sees
    logic [7:0]         ref_mem [0:65535];   // memory of the reference
    logic [31:0]        prog    [$];
    tinker_pkg::wb_t    exp_wb  [$];
    tinker_pkg::store_t exp_st  [$];
    int unsigned        rng_state = 77611;
    int                 retire_errors, store_errors, other_errors;
    logic               prog_ready = 1'b0;
    longint unsigned    watchdog_limit;

    tinker_core i_dut (
        .clk            (clk),
        .reset          (reset),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .dmem_load_addr (dmem_load_addr),
        .dmem_load_data (dmem_load_data),
        .dmem_store     (dmem_store),
        .retire         (retire),
        .hlt            (hlt)
    );

    always #20 clk = ~clk;   // period 40

    function automatic int unsigned rand_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 8;   // low bits of an lcg are weak
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return rand_next() % n;
    endfunction

    // the fifteen register-writing ops
    function automatic logic [4:0] alu_opcode(input int unsigned i);
        case (i)
            0:       return `TK_OP_ADD;
            1:       return `TK_OP_ADDI;
            2:       return `TK_OP_SUB;
            3:       return `TK_OP_SUBI;
            4:       return `TK_OP_MUL;
            5:       return `TK_OP_AND;
            6:       return `TK_OP_OR;
            7:       return `TK_OP_XOR;
            8:       return `TK_OP_NOT;
            9:       return `TK_OP_SHFTR;
            10:      return `TK_OP_SHFTRI;
            11:      return `TK_OP_SHFTL;
            12:      return `TK_OP_SHFTLI;
            13:      return `TK_OP_MOV;
            default: return `TK_OP_MOVL;
        endcase
    endfunction

    // background pattern, every address bit counts
    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3c;
    endfunction

    function automatic logic [31:0] enc(input logic [4:0] op, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [11:0] lit);
        return {op, rd, rs, rt, lit};
    endfunction

    // little endian, 8 bytes
    function automatic logic [63:0] dut_read(input logic [31:0] a);
        logic [63:0] v;
        for (int k = 0; k < 8; k++) v[8*k +: 8] = tb_mem[16'(a + k)];
        return v;
    endfunction

    function automatic logic [63:0] ref_load(input logic [31:0] a);
        logic [63:0] v;
        for (int k = 0; k < 8; k++) v[8*k +: 8] = ref_mem[16'(a + k)];
        return v;
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    // random op, never writes r0 or the reserved r20..r31
    task automatic emit_alu();
        logic [4:0]  op;
        logic [11:0] lit;
        op  = alu_opcode(rand_below(15));
        lit = 12'(rand_next());
        if (op == `TK_OP_SHFTRI || op == `TK_OP_SHFTLI) lit = lit & 12'd63;
        emit(enc(op, 5'(1 + rand_below(15)), 5'(rand_below(16)), 5'(rand_below(16)), lit));
    endtask

    task automatic emit_store_load();
        logic [11:0] off;
        off = 12'(8 * rand_below(8));   // r26 holds the data base
        emit(enc(`TK_OP_STORE, 26, 5'(rand_below(16)), 0, off));
        emit(enc(`TK_OP_LOAD, 5'(1 + rand_below(15)), 26, 0, off));
    endtask

    task automatic emit_load_use();
        logic [4:0] dst;
        dst = 5'(1 + rand_below(15));
        emit(enc(`TK_OP_LOAD, dst, 26, 0, 12'(8 * rand_below(8))));
        // next one uses it
        emit(enc(`TK_OP_ADD, 5'(1 + rand_below(15)), dst, 5'(rand_below(16)), 0));
    endtask

    // forward branch, operands settled three slots ahead
    task automatic emit_branch();
        int          kind;
        int          skip;
        int          setup;
        int          b_idx;
        logic [31:0] tgt;
        logic [4:0]  op, rd_f, rs, rt;
        logic [11:0] lit;
        kind  = rand_below(5);
        skip  = 1 + rand_below(2);
        setup = (kind == 1) ? 2 : (kind == 2) ? 0 : 4;
        b_idx = prog.size() + setup + 2;
        tgt   = `TK_PC_RESET + 4 * (b_idx + 1 + skip);
        rd_f  = 0;
        rs    = 0;
        rt    = 0;
        lit   = 0;
        case (kind)
            0:       op = `TK_OP_BR;
            1:       op = `TK_OP_BRR;
            2:       op = `TK_OP_BRRL;
            3:       op = `TK_OP_BRNZ;
            default: op = `TK_OP_BRGT;
        endcase
        if (setup == 4) begin   // absolute target built in r24
            emit(enc(`TK_OP_XOR, 24, 24, 24, 0));
            emit(enc(`TK_OP_MOVL, 24, 0, 0, tgt[15:4]));
            emit(enc(`TK_OP_SHFTLI, 24, 0, 0, 12'd4));
            emit(enc(`TK_OP_ADDI, 24, 0, 0, {8'd0, tgt[3:0]}));
            rd_f = 24;
        end else if (kind == 1) begin   // relative offset in r25
            emit(enc(`TK_OP_XOR, 25, 25, 25, 0));
            emit(enc(`TK_OP_MOVL, 25, 0, 0, 12'(4 * (1 + skip))));
            rd_f = 25;
        end else begin
            lit = 12'(4 * (1 + skip));
        end
        if (kind == 3) rs = rand_below(2) ? 5'd20 : 5'd21;   // taken or not
        if (kind == 4) begin
            rs = 5'(20 + rand_below(3));
            rt = 5'(20 + rand_below(3));
        end
        emit_alu();
        emit_alu();
        emit(enc(op, rd_f, rs, rt, lit));
        repeat (skip) emit_alu();   // skipped when taken
    endtask

    task automatic gen_program();
        for (int i = 1; i < 16; i++) emit(enc(`TK_OP_MOVL, 5'(i), 0, 0, 12'(rand_next())));
        emit(enc(`TK_OP_MOVL, 20, 0, 0, 12'd5));      // r20 = 5
        emit(enc(`TK_OP_NOT, 22, 21, 0, 0));          // r22 = -1, r21 stays 0
        emit(enc(`TK_OP_XOR, 26, 26, 26, 0));
        emit(enc(`TK_OP_MOVL, 26, 0, 0, 12'h400));
        emit(enc(`TK_OP_SHFTLI, 26, 0, 0, 12'd4));    // r26 = 0x4000
        emit(enc(`TK_OP_STORE, 26, 31, 0, 12'h040));  // exposes the reset sp
        for (int b = 0; b < 40; b++) begin
            case (rand_below(10))
                0, 1, 2, 3, 4, 5: emit_alu();
                6:                emit_store_load();
                7:                emit_load_use();
                default:          emit_branch();
            endcase
        end
        repeat (4) emit(enc(`TK_OP_HALT, 0, 0, 0, 0));   // padding behind halt stays quiet
    endtask

    task automatic load_program();
        logic [31:0] a;
        for (int i = 0; i < 65536; i++) begin
            tb_mem[i]  = fill_byte(16'(i));
            ref_mem[i] = fill_byte(16'(i));
        end
        foreach (prog[i]) begin
            a = `TK_PC_RESET + 4 * i;
            for (int k = 0; k < 4; k++) begin
                tb_mem[16'(a + k)]  = prog[i][8*k +: 8];
                ref_mem[16'(a + k)] = prog[i][8*k +: 8];
            end
        end
    endtask

    // architectural interpreter, one instruction per step
    function automatic void run_reference();
        logic [63:0]        r [32];
        logic [31:0]        pc, npc;
        tinker_pkg::instr_t ins;
        logic [63:0]        vd, vs, vt, lsx, lzx, res;
        logic               wr;
        tinker_pkg::wb_t    w;
        tinker_pkg::store_t s;
        for (int i = 0; i < 32; i++) r[i] = '0;
        r[31] = `TK_SP_RESET;
        pc = `TK_PC_RESET;
        for (int n = 0; n < 4096; n++) begin
            res = ref_load(pc);
            ins = res[31:0];
            vd  = r[ins.rd];
            vs  = r[ins.rs];
            vt  = r[ins.rt];
            lzx = {52'd0, ins.lit};
            lsx = {{52{ins.lit[11]}}, ins.lit};
            npc = pc + 4;
            wr  = 1'b1;
            case (ins.opcode)
                `TK_OP_ADD:    res = vs + vt;
                `TK_OP_ADDI:   res = vd + lzx;
                `TK_OP_SUB:    res = vs - vt;
                `TK_OP_SUBI:   res = vd - lzx;
                `TK_OP_MUL:    res = vs * vt;
                `TK_OP_AND:    res = vs & vt;
                `TK_OP_OR:     res = vs | vt;
                `TK_OP_XOR:    res = vs ^ vt;
                `TK_OP_NOT:    res = ~vs;
                `TK_OP_SHFTR:  res = vs >> vt;
                `TK_OP_SHFTRI: res = vd >> ins.lit;
                `TK_OP_SHFTL:  res = vs << vt;
                `TK_OP_SHFTLI: res = vd << ins.lit;
                `TK_OP_MOV:    res = vs;
                `TK_OP_MOVL:   res = {vd[63:12], ins.lit};
                `TK_OP_LOAD:   res = ref_load(32'(vs + lsx));
                `TK_OP_STORE: begin
                    wr     = 1'b0;
                    s.we   = 1'b1;
                    s.addr = 32'(vd + lsx);
                    s.data = vs;
                    exp_st.push_back(s);
                    for (int k = 0; k < 8; k++) ref_mem[16'(s.addr + k)] = vs[8*k +: 8];
                end
                `TK_OP_BR: begin
                    wr  = 1'b0;
                    npc = vd[31:0];
                end
                `TK_OP_BRR: begin
                    wr  = 1'b0;
                    npc = pc + vd[31:0];
                end
                `TK_OP_BRRL: begin
                    wr  = 1'b0;
                    npc = pc + lsx[31:0];
                end
                `TK_OP_BRNZ: begin
                    wr = 1'b0;
                    if (vs != 0) npc = vd[31:0];
                end
                `TK_OP_BRGT: begin
                    wr = 1'b0;
                    if ($signed(vs) > $signed(vt)) npc = vd[31:0];
                end
                `TK_OP_HALT: return;
                default:     wr = 1'b0;
            endcase
            if (wr) begin
                w.we   = 1'b1;
                w.dest = ins.rd;
                w.data = res;
                exp_wb.push_back(w);
                r[ins.rd] = res;
            end
            pc = npc;
        end
    endfunction

    task automatic check_retire(input tinker_pkg::wb_t got, input tinker_pkg::wb_t exp);
        if (got !== exp) begin
            retire_errors++;
            $display("** Error at %0t: retire r%0d = %h, expected r%0d = %h",
                     $time, got.dest, got.data, exp.dest, exp.data);
        end
    endtask

    task automatic check_store(input tinker_pkg::store_t got, input tinker_pkg::store_t exp);
        if (got !== exp) begin
            store_errors++;
            $display("** Error at %0t: store [%h] = %h, expected [%h] = %h",
                     $time, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    // memory answers on the falling edge, stores land on the rising edge
    always @(negedge clk) begin
        imem_data      <= 32'(dut_read(imem_addr));
        dmem_load_data <= dut_read(dmem_load_addr);
    end

    always @(posedge clk) begin
        if (!reset && dmem_store.we) begin
            for (int k = 0; k < 8; k++) begin
                tb_mem[16'(dmem_store.addr + k)] <= dmem_store.data[8*k +: 8];
            end
        end
    end

    initial begin
        reset          = 1'b1;
        imem_data      = '0;
        dmem_load_data = '0;
        gen_program();
        load_program();
        run_reference();
        watchdog_limit = (longint'(prog.size()) * 10 + 100 + 5) * 40;
        prog_ready     = 1'b1;
        repeat (5) begin
            @(negedge clk);
            if (retire.we !== 1'b0 || dmem_store.we !== 1'b0 || hlt !== 1'b0) begin
                other_errors++;
                $display("outputs active during reset at %0t", $time);
            end
        end
        reset = 1'b0;
        if (imem_addr !== `TK_PC_RESET) begin
            other_errors++;
            $display("first fetch address is %h, not the reset pc", imem_addr);
        end
        while (!hlt) begin
            @(negedge clk);
            // squashed slots and reset fill run as mov r0,r0
            if (retire.we && !(retire.dest == 0 && retire.data == 0)) begin
                if (exp_wb.size() == 0) begin
                    other_errors++;
                    $display("unexpected retire of r%0d at %0t", retire.dest, $time);
                end else begin
                    check_retire(retire, exp_wb.pop_front());
                end
            end
            if (dmem_store.we) begin
                if (exp_st.size() == 0) begin
                    other_errors++;
                    $display("unexpected store to %h at %0t", dmem_store.addr, $time);
                end else begin
                    check_store(dmem_store, exp_st.pop_front());
                end
            end
        end
        if (exp_wb.size() != 0 || exp_st.size() != 0) begin
            other_errors++;
            $display("halt reached with %0d writes and %0d stores still missing",
                     exp_wb.size(), exp_st.size());
        end
        $display("retire errors: %0d, store errors: %0d, other errors: %0d",
                 retire_errors, store_errors, other_errors);
        if (retire_errors + store_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // bound from program length
    initial begin
        wait (prog_ready);
        #(watchdog_limit);
        $display("timeout: hlt did not rise within %0d time units", watchdog_limit);
        $display("retire errors: %0d, store errors: %0d, other errors: %0d",
                 retire_errors, store_errors, other_errors);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== tinker.f ====
+incdir+include
src/tinker_pkg.sv
src/tinker_decode.sv
src/tinker_regfile.sv
src/tinker_branch.sv
src/tinker_hazard.sv
src/tinker_alu.sv
src/tinker_core.sv
tb/tinker_tb.sv

// ==== Bender.yml ====
package:
  name: tinker

sources:
  - include_dirs:
      - include
    files:
      - src/tinker_pkg.sv
      - src/tinker_decode.sv
      - src/tinker_regfile.sv
      - src/tinker_branch.sv
      - src/tinker_hazard.sv
      - src/tinker_alu.sv
      - src/tinker_core.sv
      - target: test
        files:
          - tb/tinker_tb.sv
